/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  // datapath widths
  localparam int data_w = 32;
  localparam int addr_w = 32;
  localparam int rsid_w = 4;

  // data RAM geometry
  localparam int ram_words = 256;
  localparam int ram_aw    = 8;
  localparam int ram_lsb   = 2;  // word index starts at byte address bit 2

  // opcode classes seen by the memory slice
  typedef enum logic [3:0] {
    op_nop = 4'h0,
    op_alu = 4'h1,  // any non-memory class
    op_lb  = 4'h2,
    op_lh  = 4'h3,
    op_lw  = 4'h4,
    op_lbu = 4'h5,
    op_lhu = 4'h6,
    op_sb  = 4'h7,
    op_sh  = 4'h8,
    op_sw  = 4'h9
  } op_t;

endpackage

`default_nettype wire

/* memory/mem_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_gen (
  input  wire                        rst,
  input  wire mem_pkg::op_t          op,
  input  wire                        rs2_is_rsid,
  input  wire  [mem_pkg::data_w-1:0] rs2_data,
  output logic                       mem_write_flag,
  output logic                       mem_read_flag,
  output logic                       mem_sign_ext_flag,
  output logic [3:0]                 mem_sel,
  output logic                       mem_write_is_rsid,
  output logic [mem_pkg::data_w-1:0] mem_write_data
);
  import mem_pkg::*;

  always_comb begin
    mem_write_flag    = 1'b0;
    mem_read_flag     = 1'b0;
    mem_sign_ext_flag = 1'b0;
    mem_sel           = 4'b0000;
    mem_write_is_rsid = 1'b0;
    mem_write_data    = '0;

    if (rst) begin
      // access class and store operand
      case (op)
        op_lb, op_lh, op_lw: begin
          mem_read_flag     = 1'b1;
          mem_sign_ext_flag = 1'b1;
        end
        op_lbu, op_lhu: begin
          mem_read_flag = 1'b1;
        end
        op_sb, op_sh, op_sw: begin
          mem_write_flag    = 1'b1;
          mem_write_is_rsid = rs2_is_rsid;  // operand may still be a producer tag
          mem_write_data    = rs2_data;
        end
        default: begin
          mem_write_flag = 1'b0;
        end
      endcase

      // lane mask before address alignment
      case (op)
        op_lb, op_lbu, op_sb: mem_sel = 4'b0001;
        op_lh, op_lhu, op_sh: mem_sel = 4'b0011;
        op_lw, op_sw:         mem_sel = 4'b1111;
        default:              mem_sel = 4'b0000;
      endcase
    end
  end

endmodule

`default_nettype wire

/* memory/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        op_valid,
  input  wire  [mem_pkg::addr_w-1:0] addr,
  input  wire  [mem_pkg::rsid_w-1:0] dest_rsid,
  input  wire                        mem_write_flag,
  input  wire                        mem_read_flag,
  input  wire                        mem_sign_ext_flag,
  input  wire  [3:0]                 mem_sel,
  input  wire                        mem_write_is_rsid,
  input  wire  [mem_pkg::data_w-1:0] mem_write_data,
  input  wire                        cdb_valid,
  input  wire  [mem_pkg::rsid_w-1:0] cdb_rsid,
  input  wire  [mem_pkg::data_w-1:0] cdb_data,
  input  wire                        lsu_gnt,
  input  wire                        lsu_rvalid,
  input  wire  [mem_pkg::data_w-1:0] rdata,
  output logic                       lsu_busy,
  output logic                       lsu_req,
  output logic [3:0]                 lsu_we,
  output logic [mem_pkg::addr_w-1:0] lsu_addr,
  output logic [mem_pkg::data_w-1:0] lsu_wdata,
  output logic                       load_valid,
  output logic [mem_pkg::rsid_w-1:0] load_rsid,
  output logic [mem_pkg::data_w-1:0] load_data,
  output logic                       store_done
);
  import mem_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wait_op,
    st_req,
    st_read
  } state_t;

  state_t            state;
  logic [addr_w-1:0] addr_q;
  logic [rsid_w-1:0] rsid_q;
  logic [3:0]        sel_q;
  logic              sign_q;
  logic              store_q;
  logic [data_w-1:0] data_q;    // store data or the producer rsid while waiting
  logic [1:0]        off;
  logic              issue;
  logic              hit_now;   // operand broadcast in the issue cycle itself
  logic              hit_wait;
  logic [data_w-1:0] rd_shift;

  assign issue    = op_valid && (mem_write_flag || mem_read_flag) && !lsu_busy;
  assign hit_now  = cdb_valid && (cdb_rsid == mem_write_data[rsid_w-1:0]);
  assign hit_wait = cdb_valid && (cdb_rsid == data_q[rsid_w-1:0]);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (issue) begin
            if (mem_write_flag && mem_write_is_rsid && !hit_now) begin
              state <= st_wait_op;
            end else begin
              state <= st_req;
            end
          end
        end
        st_wait_op: begin
          if (hit_wait) begin
            state <= st_req;
          end
        end
        st_req: begin
          if (lsu_gnt) begin
            state <= store_q ? st_idle : st_read;  // stores finish at the grant edge
          end
        end
        st_read: begin
          if (lsu_rvalid) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q  <= addr;
      rsid_q  <= dest_rsid;
      sel_q   <= mem_sel;
      sign_q  <= mem_sign_ext_flag;
      store_q <= mem_write_flag;
      data_q  <= (mem_write_is_rsid && hit_now) ? cdb_data : mem_write_data;
    end else if (state == st_wait_op && hit_wait) begin
      data_q <= cdb_data;  // snooped operand replaces the rsid
    end
  end

  assign off        = addr_q[1:0];
  assign lsu_busy   = (state != st_idle);
  assign lsu_req    = (state == st_req);
  assign lsu_addr   = addr_q;
  assign lsu_we     = store_q ? (sel_q << off) : 4'b0000;
  assign lsu_wdata  = data_q << {off, 3'b000};
  assign store_done = lsu_req && lsu_gnt && store_q;
  assign load_valid = (state == st_read) && lsu_rvalid;
  assign load_rsid  = rsid_q;

  // bring the addressed lane down to bit 0, then extend
  assign rd_shift = rdata >> {off, 3'b000};

  always_comb begin
    case (sel_q)
      4'b0001: load_data = {{(data_w-8){sign_q && rd_shift[7]}}, rd_shift[7:0]};
      4'b0011: load_data = {{(data_w-16){sign_q && rd_shift[15]}}, rd_shift[15:0]};
      default: load_data = rd_shift;
    endcase
  end

endmodule

`default_nettype wire

/* memory/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  wire                        clk,
  input  wire                        ram_en,
  input  wire  [3:0]                 ram_we,
  input  wire  [mem_pkg::ram_aw-1:0] ram_addr,
  input  wire  [mem_pkg::data_w-1:0] ram_wdata,
  output logic [mem_pkg::data_w-1:0] ram_rdata
);
  import mem_pkg::*;

  logic [data_w-1:0] mem [ram_words];

  // byte-lane writes
  always_ff @(posedge clk) begin
    if (ram_en) begin
      for (int i = 0; i < 4; i++) begin
        if (ram_we[i]) begin
          mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
        end
      end
    end
  end

  // registered read returns old contents on a write cycle
  always_ff @(posedge clk) begin
    if (ram_en) begin
      ram_rdata <= mem[ram_addr];
    end
  end

endmodule

`default_nettype wire

/* logic/inst_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_fetch (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        fetch_en,
  input  wire                        redirect,
  input  wire  [mem_pkg::addr_w-1:0] redirect_pc,
  input  wire                        fetch_gnt,
  input  wire                        fetch_rvalid,
  input  wire  [mem_pkg::data_w-1:0] rdata,
  output logic                       fetch_req,
  output logic [mem_pkg::addr_w-1:0] fetch_addr,
  output logic                       inst_valid,
  output logic [mem_pkg::addr_w-1:0] inst_pc,
  output logic [mem_pkg::data_w-1:0] inst
);
  import mem_pkg::*;

  logic [addr_w-1:0] pc_q;
  logic [addr_w-1:0] rd_pc_q;   // pc of the read in flight
  logic              squash_q;

  // a read always returns the next cycle, so a new request may overlap it
  assign fetch_req  = fetch_en;
  assign fetch_addr = pc_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc_q     <= '0;
      squash_q <= 1'b0;
    end else begin
      squash_q <= redirect && fetch_gnt;  // read granted now targets the old pc
      if (redirect) begin
        pc_q <= redirect_pc;
      end else if (fetch_gnt) begin
        pc_q <= pc_q + addr_w'(4);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_gnt) begin
      rd_pc_q <= pc_q;
    end
  end

  // a return in the redirect cycle is stale too
  assign inst_valid = fetch_rvalid && !squash_q && !redirect;
  assign inst_pc    = rd_pc_q;
  assign inst       = rdata;

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        lsu_req,
  input  wire  [3:0]                 lsu_we,
  input  wire  [mem_pkg::addr_w-1:0] lsu_addr,
  input  wire  [mem_pkg::data_w-1:0] lsu_wdata,
  input  wire                        fetch_req,
  input  wire  [mem_pkg::addr_w-1:0] fetch_addr,
  input  wire  [mem_pkg::data_w-1:0] ram_rdata,
  output logic                       lsu_gnt,
  output logic                       fetch_gnt,
  output logic                       lsu_rvalid,
  output logic                       fetch_rvalid,
  output logic [mem_pkg::data_w-1:0] rdata,
  output logic                       ram_en,
  output logic [3:0]                 ram_we,
  output logic [mem_pkg::ram_aw-1:0] ram_addr,
  output logic [mem_pkg::data_w-1:0] ram_wdata
);
  import mem_pkg::*;

  logic last_lsu;    // lsu won the previous grant
  logic rd_lsu_q;
  logic rd_fetch_q;

  // on a tie the side that did not win last time goes first
  assign lsu_gnt   = lsu_req && (!fetch_req || !last_lsu);
  assign fetch_gnt = fetch_req && !lsu_gnt;

  assign ram_en    = lsu_gnt || fetch_gnt;
  assign ram_we    = lsu_gnt ? lsu_we : 4'b0000;
  assign ram_addr  = lsu_gnt ? lsu_addr[ram_lsb +: ram_aw] : fetch_addr[ram_lsb +: ram_aw];
  assign ram_wdata = lsu_wdata;

  always_ff @(posedge clk) begin
    if (!rst) begin
      last_lsu   <= 1'b0;
      rd_lsu_q   <= 1'b0;
      rd_fetch_q <= 1'b0;
    end else begin
      if (ram_en) begin
        last_lsu <= lsu_gnt;
      end
      rd_lsu_q   <= lsu_gnt && (lsu_we == 4'b0000);  // stores return nothing
      rd_fetch_q <= fetch_gnt;
    end
  end

  assign lsu_rvalid   = rd_lsu_q;
  assign fetch_rvalid = rd_fetch_q;
  assign rdata        = ram_rdata;

endmodule

`default_nettype wire

/* logic/mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        op_valid,
  input  wire mem_pkg::op_t          op,
  input  wire  [mem_pkg::addr_w-1:0] addr,
  input  wire  [mem_pkg::data_w-1:0] rs2_data,
  input  wire                        rs2_is_rsid,
  input  wire  [mem_pkg::rsid_w-1:0] dest_rsid,
  input  wire                        cdb_valid,
  input  wire  [mem_pkg::rsid_w-1:0] cdb_rsid,
  input  wire  [mem_pkg::data_w-1:0] cdb_data,
  input  wire                        fetch_en,
  input  wire                        redirect,
  input  wire  [mem_pkg::addr_w-1:0] redirect_pc,
  output logic                       lsu_busy,
  output logic                       load_valid,
  output logic [mem_pkg::rsid_w-1:0] load_rsid,
  output logic [mem_pkg::data_w-1:0] load_data,
  output logic                       store_done,
  output logic                       inst_valid,
  output logic [mem_pkg::addr_w-1:0] inst_pc,
  output logic [mem_pkg::data_w-1:0] inst
);
  import mem_pkg::*;

  // decoded access
  logic              mem_write_flag;
  logic              mem_read_flag;
  logic              mem_sign_ext_flag;
  logic [3:0]        mem_sel;
  logic              mem_write_is_rsid;
  logic [data_w-1:0] mem_write_data;

  // requester side of the arbiter
  logic              lsu_req;
  logic [3:0]        lsu_we;
  logic [addr_w-1:0] lsu_addr;
  logic [data_w-1:0] lsu_wdata;
  logic              lsu_gnt;
  logic              lsu_rvalid;
  logic              fetch_req;
  logic [addr_w-1:0] fetch_addr;
  logic              fetch_gnt;
  logic              fetch_rvalid;
  logic [data_w-1:0] rdata;

  // RAM port
  logic              ram_en;
  logic [3:0]        ram_we;
  logic [ram_aw-1:0] ram_addr;
  logic [data_w-1:0] ram_wdata;
  logic [data_w-1:0] ram_rdata;

  mem_gen i_mem_gen (
    .rst               (rst),
    .op                (op),
    .rs2_is_rsid       (rs2_is_rsid),
    .rs2_data          (rs2_data),
    .mem_write_flag    (mem_write_flag),
    .mem_read_flag     (mem_read_flag),
    .mem_sign_ext_flag (mem_sign_ext_flag),
    .mem_sel           (mem_sel),
    .mem_write_is_rsid (mem_write_is_rsid),
    .mem_write_data    (mem_write_data)
  );

  lsu i_lsu (
    .clk               (clk),
    .rst               (rst),
    .op_valid          (op_valid),
    .addr              (addr),
    .dest_rsid         (dest_rsid),
    .mem_write_flag    (mem_write_flag),
    .mem_read_flag     (mem_read_flag),
    .mem_sign_ext_flag (mem_sign_ext_flag),
    .mem_sel           (mem_sel),
    .mem_write_is_rsid (mem_write_is_rsid),
    .mem_write_data    (mem_write_data),
    .cdb_valid         (cdb_valid),
    .cdb_rsid          (cdb_rsid),
    .cdb_data          (cdb_data),
    .lsu_gnt           (lsu_gnt),
    .lsu_rvalid        (lsu_rvalid),
    .rdata             (rdata),
    .lsu_busy          (lsu_busy),
    .lsu_req           (lsu_req),
    .lsu_we            (lsu_we),
    .lsu_addr          (lsu_addr),
    .lsu_wdata         (lsu_wdata),
    .load_valid        (load_valid),
    .load_rsid         (load_rsid),
    .load_data         (load_data),
    .store_done        (store_done)
  );

  inst_fetch i_inst_fetch (
    .clk          (clk),
    .rst          (rst),
    .fetch_en     (fetch_en),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .fetch_gnt    (fetch_gnt),
    .fetch_rvalid (fetch_rvalid),
    .rdata        (rdata),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .inst_valid   (inst_valid),
    .inst_pc      (inst_pc),
    .inst         (inst)
  );

  mem_arbiter i_mem_arbiter (
    .clk          (clk),
    .rst          (rst),
    .lsu_req      (lsu_req),
    .lsu_we       (lsu_we),
    .lsu_addr     (lsu_addr),
    .lsu_wdata    (lsu_wdata),
    .fetch_req    (fetch_req),
    .fetch_addr   (fetch_addr),
    .ram_rdata    (ram_rdata),
    .lsu_gnt      (lsu_gnt),
    .fetch_gnt    (fetch_gnt),
    .lsu_rvalid   (lsu_rvalid),
    .fetch_rvalid (fetch_rvalid),
    .rdata        (rdata),
    .ram_en       (ram_en),
    .ram_we       (ram_we),
    .ram_addr     (ram_addr),
    .ram_wdata    (ram_wdata)
  );

  data_ram i_data_ram (
    .clk       (clk),
    .ram_en    (ram_en),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_rdata (ram_rdata)
  );

endmodule

`default_nettype wire

/* test/mem_subsys_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_assert (
  input wire                       clk,
  input wire                       rst,
  input wire                       op_valid,
  input wire [mem_pkg::addr_w-1:0] addr,
  input wire                       mem_write_flag,
  input wire                       mem_read_flag,
  input wire [3:0]                 mem_sel,
  input wire                       lsu_busy,
  input wire                       lsu_gnt,
  input wire                       fetch_gnt,
  input wire                       load_valid,
  input wire                       store_done
);

  logic mem_access;
  logic aligned;

  assign mem_access = op_valid && (mem_write_flag || mem_read_flag);
  assign aligned    = (mem_sel == 4'b0011) ? !addr[0] :
                      (mem_sel == 4'b1111) ? (addr[1:0] == 2'b00) : 1'b1;

  no_issue_while_busy: assert property (@(posedge clk) disable iff (!rst)
    !(op_valid && lsu_busy))
    else $error("op_valid pulsed while the load/store unit was busy");

  single_grant: assert property (@(posedge clk) disable iff (!rst)
    !(lsu_gnt && fetch_gnt))
    else $error("both requesters granted in one cycle");

  access_aligned: assert property (@(posedge clk) disable iff (!rst)
    mem_access |-> aligned)
    else $error("misaligned access issued at address %h", addr);

  one_completion: assert property (@(posedge clk) disable iff (!rst)
    !(load_valid && store_done))
    else $error("load_valid and store_done high together");

endmodule

bind mem_subsys mem_subsys_assert i_mem_subsys_assert (
  .clk            (clk),
  .rst            (rst),
  .op_valid       (op_valid),
  .addr           (addr),
  .mem_write_flag (mem_write_flag),
  .mem_read_flag  (mem_read_flag),
  .mem_sel        (mem_sel),
  .lsu_busy       (lsu_busy),
  .lsu_gnt        (lsu_gnt),
  .fetch_gnt      (fetch_gnt),
  .load_valid     (load_valid),
  .store_done     (store_done)
);

`default_nettype wire

/* test/tb_mem_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
  import mem_pkg::*;

  localparam int num_tests    = 7;  // memory fill plus six directed tests
  localparam int wd_cycles    = num_tests * 400 + ram_words * 6 + 100;
  localparam int wait_cycles  = 64;

  logic              clk;
  logic              rst;
  logic              op_valid;
  op_t               op;
  logic [addr_w-1:0] addr;
  logic [data_w-1:0] rs2_data;
  logic              rs2_is_rsid;
  logic [rsid_w-1:0] dest_rsid;
  logic              cdb_valid;
  logic [rsid_w-1:0] cdb_rsid;
  logic [data_w-1:0] cdb_data;
  logic              fetch_en;
  logic              redirect;
  logic [addr_w-1:0] redirect_pc;
  logic              lsu_busy;
  logic              load_valid;
  logic [rsid_w-1:0] load_rsid;
  logic [data_w-1:0] load_data;
  logic              store_done;
  logic              inst_valid;
  logic [addr_w-1:0] inst_pc;
  logic [data_w-1:0] inst;

  logic [7:0]        model [1024];  // byte image of the RAM indexed by address bits 9:0
  int                errors;
  int                checks;
  int                fetch_cnt;
  logic [addr_w-1:0] exp_pc;
  logic [data_w-1:0] got_data;
  logic [rsid_w-1:0] got_rsid;
  int unsigned       seed;

  mem_subsys i_dut (
    .clk         (clk),
    .rst         (rst),
    .op_valid    (op_valid),
    .op          (op),
    .addr        (addr),
    .rs2_data    (rs2_data),
    .rs2_is_rsid (rs2_is_rsid),
    .dest_rsid   (dest_rsid),
    .cdb_valid   (cdb_valid),
    .cdb_rsid    (cdb_rsid),
    .cdb_data    (cdb_data),
    .fetch_en    (fetch_en),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .lsu_busy    (lsu_busy),
    .load_valid  (load_valid),
    .load_rsid   (load_rsid),
    .load_data   (load_data),
    .store_done  (store_done),
    .inst_valid  (inst_valid),
    .inst_pc     (inst_pc),
    .inst        (inst)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic report(input string msg);
    errors++;
    $display("Error: %s", msg);
  endtask

  function automatic logic [31:0] model_word(input logic [31:0] a);
    int b;
    b = {a[9:2], 2'b00};
    return {model[b+3], model[b+2], model[b+1], model[b]};
  endfunction

  function automatic int op_size(input op_t o);
    case (o)
      op_sb, op_lb, op_lbu: return 1;
      op_sh, op_lh, op_lhu: return 2;
      default:              return 4;
    endcase
  endfunction

  function automatic logic [31:0] rand_data_addr();
    return 32'h200 | ($urandom & 32'h1fc);  // word aligned in the upper half of the RAM
  endfunction

  task automatic model_store(input logic [31:0] a, input int size, input logic [31:0] d);
    for (int i = 0; i < size; i++) begin
      model[int'(a[9:0]) + i] = d[8*i +: 8];
    end
  endtask

  task automatic issue(input op_t o, input logic [31:0] a, input logic [31:0] d,
                       input logic is_rsid, input logic [3:0] rsid);
    @(negedge clk);
    op          = o;
    addr        = a;
    rs2_data    = d;
    rs2_is_rsid = is_rsid;
    dest_rsid   = rsid;
    op_valid    = 1'b1;
    @(negedge clk);
    op_valid = 1'b0;
  endtask

  task automatic await_done(input logic want_load, input string what, output logic ok);
    ok = 1'b0;
    for (int n = 0; n < wait_cycles && !ok; n++) begin
      @(posedge clk);
      if (want_load ? load_valid : store_done) begin
        ok       = 1'b1;
        got_data = load_data;
        got_rsid = load_rsid;
      end
    end
    if (!ok) begin
      report({"no ", what});
    end
  endtask

  task automatic store_and_update(input op_t o, input logic [31:0] a, input logic [31:0] d);
    logic ok;
    issue(o, a, d, 1'b0, 4'h0);
    await_done(1'b0, "store_done after store issue", ok);
    @(negedge clk);  // write landed at the grant edge
    if (ok) begin
      model_store(a, op_size(o), d);
    end
  endtask

  task automatic load_and_check(input op_t o, input logic [31:0] a);
    logic        ok;
    logic [3:0]  rsid;
    logic [31:0] w;
    logic [31:0] exp;
    rsid = 4'($urandom);
    issue(o, a, 32'h0, 1'b0, rsid);
    await_done(1'b1, "load_valid after load issue", ok);
    if (ok) begin
      w = model_word(a) >> (8 * a[1:0]);  // addressed lane down to bit 0
      case (o)
        op_lb:   exp = {{24{w[7]}}, w[7:0]};
        op_lbu:  exp = {24'h0, w[7:0]};
        op_lh:   exp = {{16{w[15]}}, w[15:0]};
        op_lhu:  exp = {16'h0, w[15:0]};
        default: exp = w;
      endcase
      check("load_data", got_data, exp);
      check("load_rsid", got_rsid, rsid);
    end
  endtask

  task automatic wait_fetches(input int target, input string what);
    int n;
    n = 0;
    while (fetch_cnt < target && n < wait_cycles) begin
      @(negedge clk);
      n++;
    end
    if (fetch_cnt < target) begin
      report({"too few ", what});
    end
  endtask

  task automatic fill_memory();
    for (int w = 0; w < ram_words; w++) begin
      store_and_update(op_sw, 32'(w * 4), $urandom);
    end
  endtask

  task automatic word_round_trip();
    logic [31:0] a;
    repeat (8) begin
      a = rand_data_addr();
      store_and_update(op_sw, a, $urandom);
      load_and_check(op_lw, a);
    end
  endtask

  task automatic sub_word_lanes();
    logic [31:0] a;
    repeat (3) begin
      a = rand_data_addr();
      for (int off = 0; off < 4; off++) begin
        store_and_update(op_sb, a + off, off[0] ? ($urandom & 32'h7f) : ($urandom | 32'h80));
      end
      for (int off = 0; off < 4; off++) begin
        load_and_check(op_lb, a + off);
        load_and_check(op_lbu, a + off);
      end
      for (int off = 0; off < 4; off += 2) begin
        store_and_update(op_sh, a + off,
                         off[1] ? ($urandom & 32'h7fff) : ($urandom | 32'h8000));
        load_and_check(op_lh, a + off);
        load_and_check(op_lhu, a + off);
      end
      load_and_check(op_lw, a);  // merged word
    end
  endtask

  task automatic pending_store_operand();
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  tag;
    logic        ok;
    repeat (2) begin
      a   = rand_data_addr();
      d   = $urandom;
      tag = 4'($urandom);
      issue(op_sw, a, 32'(tag), 1'b1, 4'h0);
      for (int k = 1; k < 6; k++) begin
        @(negedge clk);
        cdb_valid = 1'b1;
        cdb_rsid  = tag + 4'(k);  // some other producer
        cdb_data  = $urandom;
        @(posedge clk);
        check("store_done", store_done, 32'h0);
        check("lsu_busy", lsu_busy, 32'h1);
      end
      @(negedge clk);
      cdb_rsid = tag;
      cdb_data = d;
      @(negedge clk);
      cdb_valid = 1'b0;
      await_done(1'b0, "store_done after matching CDB broadcast", ok);
      @(negedge clk);
      if (ok) begin
        model_store(a, 4, d);
      end
      load_and_check(op_lw, a);
    end
  endtask

  task automatic non_memory_ignored();
    op_t ops [2];
    ops[0] = op_nop;
    ops[1] = op_alu;
    foreach (ops[i]) begin
      issue(ops[i], rand_data_addr(), $urandom, 1'b0, 4'h5);
      repeat (3) begin
        @(posedge clk);
        check("store_done", store_done, 32'h0);
        check("load_valid", load_valid, 32'h0);
        check("lsu_busy", lsu_busy, 32'h0);
      end
    end
  endtask

  task automatic fetch_stream();
    logic [31:0] start;
    start = 32'h080;
    for (int i = 0; i < 8; i++) begin
      store_and_update(op_sw, start + 4 * i, $urandom);
    end
    @(negedge clk);
    redirect    = 1'b1;
    redirect_pc = start;
    @(negedge clk);
    redirect = 1'b0;
    fetch_en = 1'b1;
    wait_fetches(fetch_cnt + 8, "inst_valid pulses in the fetch stream");
    fetch_en = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic fetch_under_traffic();
    logic [31:0] a;
    int          base;
    base = 0;
    @(negedge clk);
    fetch_en = 1'b1;
    for (int i = 0; i < 12; i++) begin
      a = rand_data_addr();
      if (i == 6) begin
        @(negedge clk);
        redirect    = 1'b1;
        redirect_pc = $urandom & 32'h0fc;
        @(negedge clk);
        redirect = 1'b0;
        base     = fetch_cnt;
      end
      case (i % 3)
        0: begin
          store_and_update(op_sw, a, $urandom);
          load_and_check(op_lw, a);
        end
        1: begin
          store_and_update(op_sh, a + 2, $urandom);
          load_and_check(op_lh, a + 2);
        end
        default: begin
          store_and_update(op_sb, a + 3, $urandom);
          load_and_check(op_lbu, a + 3);
        end
      endcase
    end
    if (fetch_cnt <= base) begin
      report("no inst_valid after redirect");
    end
    fetch_en = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  // every returned instruction against the expected pc and the model
  always @(posedge clk) begin
    if (rst && inst_valid) begin
      check("inst_pc", inst_pc, exp_pc);
      check("inst", inst, model_word(exp_pc));
      exp_pc = exp_pc + 4;
      fetch_cnt++;
    end
    if (rst && redirect) begin
      exp_pc = redirect_pc;
    end
  end

  initial begin
    repeat (wd_cycles) @(posedge clk);
    $display("Error: watchdog expired after %0d cycles", wd_cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    seed        = $urandom(32'h03868b79);
    errors      = 0;
    checks      = 0;
    fetch_cnt   = 0;
    exp_pc      = '0;
    rst         = 1'b0;
    op_valid    = 1'b0;
    op          = op_nop;
    addr        = '0;
    rs2_data    = '0;
    rs2_is_rsid = 1'b0;
    dest_rsid   = '0;
    cdb_valid   = 1'b0;
    cdb_rsid    = '0;
    cdb_data    = '0;
    fetch_en    = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    repeat (10) @(negedge clk);
    rst = 1'b1;
    @(posedge clk);
    check("lsu_busy", lsu_busy, 32'h0);
    check("inst_valid", inst_valid, 32'h0);
    fill_memory();
    word_round_trip();
    sub_word_lanes();
    pending_store_operand();
    non_memory_ignored();
    fetch_stream();
    fetch_under_traffic();
    @(negedge clk);
    $display("checks %0d, errors %0d, fetches %0d", checks, errors, fetch_cnt);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_subsys.f */
common/mem_pkg.sv
memory/mem_gen.sv
memory/lsu.sv
memory/data_ram.sv
logic/inst_fetch.sv
logic/mem_arbiter.sv
logic/mem_subsys.sv
test/mem_subsys_assert.sv
test/tb_mem_subsys.sv
